//--- build.f
hw/fetch_pkg.sv
hw/fetch_if.sv
hw/next_pc_predictor.sv
hw/pc_gen.sv
hw/icache.sv
hw/instr_fifo.sv
hw/ifu.sv
+incdir+include
verification/ifu_checker.sv
verification/ifu_properties.sv
verification/tb_ifu.sv

//--- hw/fetch_if.sv
`timescale 1ns/1ps

// one fetched instruction plus its prediction, pc stage -> instruction fifo
interface fetch_if;

    logic               valid;       // cache hit, not redirected, not stalled
    logic               ready;       // fifo not full
    fetch_pkg::instr_t  instr;
    fetch_pkg::addr_t   pc;
    logic               is_cond_br;  // conditional branch decoded
    logic               br_taken;    // predicted direction
    fetch_pkg::addr_t   br_target;   // predicted next pc

    // producer side
    modport src (
        output valid,
        output instr,
        output pc,
        output is_cond_br,
        output br_taken,
        output br_target,
        input  ready
    );

    // consumer side
    modport dst (
        input  valid,
        input  instr,
        input  pc,
        input  is_cond_br,
        input  br_taken,
        input  br_target,
        output ready
    );

endinterface

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // basic widths
    localparam int ADDR_W       = 32;
    localparam int INSTR_W      = 32;
    localparam int BLOCK_W      = 64;                  // two instructions per block
    localparam int OFFSET_W     = 3;                   // byte offset inside a block
    localparam int BLOCK_ADDR_W = ADDR_W - OFFSET_W;   // 29

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // one instruction word
    typedef logic [INSTR_W-1:0] instr_t;

    // one cache block, also one memory beat
    typedef logic [BLOCK_W-1:0] block_t;

    // address without the low offset bits
    typedef logic [BLOCK_ADDR_W-1:0] block_addr_t;

    // cache geometry and queue defaults, passed down from ifu
    localparam int NUM_SETS_DEFAULT   = 16;
    localparam int FIFO_DEPTH_DEFAULT = 8;

    // opcodes seen by the static predictor
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    // refill controller of the icache
    typedef enum logic [1:0] {
        IDLE = 2'd0,   // lookup only
        REQ  = 2'd1,   // block request held on the memory port
        WAIT = 2'd2    // request accepted, waiting for the beat
    } refill_state_e;

endpackage

//--- hw/icache.sv
`timescale 1ns/1ps

// direct mapped icache, one 64 bit block per set, refill over req/resp port
module icache #(
    parameter int NUM_SETS = fetch_pkg::NUM_SETS_DEFAULT
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  fetch_pkg::addr_t         pc,
    output logic                     hit,
    output fetch_pkg::instr_t        instr,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output fetch_pkg::block_addr_t   mem_req_addr,
    input  logic                     mem_resp_valid,
    input  fetch_pkg::block_t        mem_resp_data
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = fetch_pkg::BLOCK_ADDR_W - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // arrays
    logic [NUM_SETS-1:0] valid_q;
    tag_t                tag_mem  [NUM_SETS];
    fetch_pkg::block_t   data_mem [NUM_SETS];

    fetch_pkg::block_addr_t   pc_blk;
    idx_t                     pc_idx;
    tag_t                     pc_tag;
    fetch_pkg::block_t        rd_block;

    fetch_pkg::refill_state_e state_q;
    fetch_pkg::refill_state_e state_nxt;
    fetch_pkg::block_addr_t   miss_blk_q;   // block being refilled
    idx_t                     miss_idx;
    tag_t                     miss_tag;
    logic                     fill;

    // lookup
    assign pc_blk   = pc[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W];
    assign pc_idx   = pc_blk[IDX_W-1:0];
    assign pc_tag   = pc_blk[fetch_pkg::BLOCK_ADDR_W-1:IDX_W];
    assign rd_block = data_mem[pc_idx];

    assign hit   = valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag);
    assign instr = pc[2] ? rd_block[63:32] : rd_block[31:0];   // upper word at +4

    assign miss_idx = miss_blk_q[IDX_W-1:0];
    assign miss_tag = miss_blk_q[fetch_pkg::BLOCK_ADDR_W-1:IDX_W];

    // the beat is only taken while waiting for it
    assign fill = (state_q == fetch_pkg::WAIT) && mem_resp_valid;

    assign mem_req_valid = (state_q == fetch_pkg::REQ);
    assign mem_req_addr  = miss_blk_q;

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            fetch_pkg::IDLE: if (!hit) state_nxt = fetch_pkg::REQ;
            fetch_pkg::REQ:  if (mem_req_ready) state_nxt = fetch_pkg::WAIT;
            fetch_pkg::WAIT: if (mem_resp_valid) state_nxt = fetch_pkg::IDLE;
            default:         state_nxt = fetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= fetch_pkg::IDLE;
            valid_q <= '0;                  // cold cache
        end else begin
            state_q <= state_nxt;
            if (fill) begin
                valid_q[miss_idx] <= 1'b1;
            end
        end
    end

    // miss address latched once, kept through REQ and WAIT even across a redirect
    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::IDLE && !hit) begin
            miss_blk_q <= pc_blk;
        end
    end

    // tag and data written together on the returning beat
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[miss_idx]  <= miss_tag;
            data_mem[miss_idx] <= mem_resp_data;
        end
    end

endmodule

//--- hw/ifu.sv
`timescale 1ns/1ps

// instruction fetch unit: pc stage, icache and instruction fifo
module ifu #(
    parameter int NUM_SETS   = fetch_pkg::NUM_SETS_DEFAULT,
    parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   arst_n,
    // backend
    input  logic                   recovery_valid,
    input  fetch_pkg::addr_t       recovery_pc,
    input  logic                   backend_stall,
    // memory request
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    output fetch_pkg::block_addr_t mem_req_addr,
    // memory response, one cycle pulse
    input  logic                   mem_resp_valid,
    input  fetch_pkg::block_t      mem_resp_data,
    // dispatch
    output logic                   dispatch_valid,
    input  logic                   dispatch_ready,
    output fetch_pkg::instr_t      dispatch_instr,
    output fetch_pkg::addr_t       dispatch_pc,
    output logic                   dispatch_is_cond_br,
    output logic                   dispatch_br_taken,
    output fetch_pkg::addr_t       dispatch_br_target
);

    fetch_pkg::addr_t  pc;
    logic              hit;
    fetch_pkg::instr_t instr;

    fetch_if fetch_bus ();

    pc_gen pc_gen_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .recovery_valid (recovery_valid),
        .recovery_pc    (recovery_pc),
        .backend_stall  (backend_stall),
        .hit            (hit),
        .instr          (instr),
        .pc             (pc),
        .fetch          (fetch_bus.src)
    );

    icache #(
        .NUM_SETS (NUM_SETS)
    ) icache_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc             (pc),
        .hit            (hit),
        .instr          (instr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    // recovery flushes the queue in the same cycle it loads the pc
    instr_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) instr_fifo_i (
        .clk                 (clk),
        .arst_n              (arst_n),
        .flush               (recovery_valid),
        .enq                 (fetch_bus.dst),
        .dispatch_valid      (dispatch_valid),
        .dispatch_ready      (dispatch_ready),
        .dispatch_instr      (dispatch_instr),
        .dispatch_pc         (dispatch_pc),
        .dispatch_is_cond_br (dispatch_is_cond_br),
        .dispatch_br_taken   (dispatch_br_taken),
        .dispatch_br_target  (dispatch_br_target)
    );

endmodule

//--- hw/instr_fifo.sv
`timescale 1ns/1ps

// circular instruction queue, fetch -> dispatch, flushed on redirect
module instr_fifo #(
    parameter int DEPTH = fetch_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              flush,
    fetch_if.dst              enq,
    output logic              dispatch_valid,
    input  logic              dispatch_ready,
    output fetch_pkg::instr_t dispatch_instr,
    output fetch_pkg::addr_t  dispatch_pc,
    output logic              dispatch_is_cond_br,
    output logic              dispatch_br_taken,
    output fetch_pkg::addr_t  dispatch_br_target
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // entry storage, one array per field
    fetch_pkg::instr_t instr_mem  [DEPTH];
    fetch_pkg::addr_t  pc_mem     [DEPTH];
    logic              cond_mem   [DEPTH];
    logic              taken_mem  [DEPTH];
    fetch_pkg::addr_t  target_mem [DEPTH];

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t count_q;
    logic do_enq;
    logic do_deq;

    assign enq.ready = (count_q != cnt_t'(DEPTH));   // not full

    // nothing moves in the flush cycle
    assign do_enq = enq.valid & enq.ready & ~flush;
    assign do_deq = dispatch_valid & dispatch_ready;

    assign dispatch_valid      = (count_q != '0) & ~flush;
    assign dispatch_instr      = instr_mem[rd_ptr_q];
    assign dispatch_pc         = pc_mem[rd_ptr_q];
    assign dispatch_is_cond_br = cond_mem[rd_ptr_q];
    assign dispatch_br_taken   = taken_mem[rd_ptr_q];
    assign dispatch_br_target  = target_mem[rd_ptr_q];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;   // drop everything queued
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_deq) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            instr_mem[wr_ptr_q]  <= enq.instr;
            pc_mem[wr_ptr_q]     <= enq.pc;
            cond_mem[wr_ptr_q]   <= enq.is_cond_br;
            taken_mem[wr_ptr_q]  <= enq.br_taken;
            target_mem[wr_ptr_q] <= enq.br_target;
        end
    end

endmodule

//--- hw/next_pc_predictor.sv
`timescale 1ns/1ps

// static prediction: jal taken, backward branch taken, forward branch not taken
module next_pc_predictor (
    input  fetch_pkg::instr_t instr,
    input  fetch_pkg::addr_t  pc,
    output logic              is_cond_br,
    output logic              br_taken,
    output fetch_pkg::addr_t  next_pc
);

    logic [6:0]       opcode;
    logic             is_jal;
    logic             cond_taken;
    fetch_pkg::addr_t b_imm;     // sign extended b-type offset
    fetch_pkg::addr_t j_imm;     // sign extended j-type offset

    assign opcode = instr[6:0];

    // b-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // j-type: imm[20|10:1|11|19:12] in 31:12
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign is_jal     = (opcode == fetch_pkg::OPCODE_JAL);
    assign is_cond_br = (opcode == fetch_pkg::OPCODE_BRANCH);

    // sign bit of the offset decides direction
    assign cond_taken = is_cond_br & instr[31];

    assign br_taken = is_jal | cond_taken;

    always_comb begin
        if (is_jal) begin
            next_pc = pc + j_imm;
        end else if (cond_taken) begin
            next_pc = pc + b_imm;      // loop back edge
        end else begin
            next_pc = pc + 32'd4;      // fall through, also for not-taken branch
        end
    end

endmodule

//--- hw/pc_gen.sv
`timescale 1ns/1ps

// pc register, next pc mux and the fetch handshake toward the fifo
module pc_gen (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              recovery_valid,   // backend redirect
    input  fetch_pkg::addr_t  recovery_pc,
    input  logic              backend_stall,
    input  logic              hit,              // icache lookup on pc
    input  fetch_pkg::instr_t instr,            // word selected by pc[2]
    output fetch_pkg::addr_t  pc,
    fetch_if.src              fetch
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t pc_nxt;
    fetch_pkg::addr_t pred_pc;
    logic             pred_is_cond_br;
    logic             pred_taken;
    logic             stall;

    next_pc_predictor predictor_i (
        .instr      (instr),
        .pc         (pc_q),
        .is_cond_br (pred_is_cond_br),
        .br_taken   (pred_taken),
        .next_pc    (pred_pc)
    );

    // any reason to keep the current pc
    assign stall = ~hit | ~fetch.ready | backend_stall;

    // offer the word only when the pc is going to move with it
    assign fetch.valid      = hit & ~backend_stall & ~recovery_valid;
    assign fetch.instr      = instr;
    assign fetch.pc         = pc_q;
    assign fetch.is_cond_br = pred_is_cond_br;
    assign fetch.br_taken   = pred_taken;
    assign fetch.br_target  = pred_pc;

    always_comb begin
        if (recovery_valid) begin
            pc_nxt = recovery_pc;        // redirect wins over everything
        end else if (stall) begin
            pc_nxt = pc_q;               // miss, fifo full or backend stall
        end else begin
            pc_nxt = pred_pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= '0;                  // boot from address 0
        end else begin
            pc_q <= pc_nxt;
        end
    end

    assign pc = pc_q;   // drives the cache lookup

endmodule

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program image as a pure function of the byte address
// word 6 of each 64 byte group: forward branch, word 10: jal, word 13: backward branch
function automatic fetch_pkg::instr_t tb_program_word(input fetch_pkg::addr_t addr);
    logic [12:0]       b_off;
    logic [20:0]       j_off;
    fetch_pkg::instr_t word;
    b_off = '0;
    j_off = '0;
    case (addr[5:2])
        4'd6: begin
            b_off = 13'sd16;     // forward, predicted not taken
            word  = {b_off[12], b_off[10:5], 5'd2, 5'd1, 3'b000, b_off[4:1], b_off[11],
                     fetch_pkg::OPCODE_BRANCH};
        end
        4'd10: begin
            j_off = 21'h000c4;   // lands on word 11 three groups ahead
            word  = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], 5'd1,
                     fetch_pkg::OPCODE_JAL};
        end
        4'd13: begin
            b_off = -13'sd24;    // back to word 7, predicted taken
            word  = {b_off[12], b_off[10:5], 5'd3, 5'd1, 3'b001, b_off[4:1], b_off[11],
                     fetch_pkg::OPCODE_BRANCH};
        end
        default: word = {addr[13:2], 5'd1, 3'b000, 5'd1, 7'b0010011};   // addi x1, x1, imm
    endcase
    return word;
endfunction

`endif

//--- verification/ifu_checker.sv
`timescale 1ns/1ps

// reference fetch model, follows the predicted path and compares each dispatch
module ifu_checker #(
    parameter int NUM_SETS = fetch_pkg::NUM_SETS_DEFAULT
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   recovery_valid,
    input  fetch_pkg::addr_t       recovery_pc,
    input  logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    input  fetch_pkg::block_addr_t mem_req_addr,
    input  logic                   mem_resp_valid,
    input  logic                   dispatch_valid,
    input  logic                   dispatch_ready,
    input  fetch_pkg::instr_t      dispatch_instr,
    input  fetch_pkg::addr_t       dispatch_pc,
    input  logic                   dispatch_is_cond_br,
    input  logic                   dispatch_br_taken,
    input  fetch_pkg::addr_t       dispatch_br_target,
    output int                     dispatched,
    output int                     errors
);

`include "tb_program.svh"

    localparam int IDX_W = $clog2(NUM_SETS);

    fetch_pkg::addr_t exp_pc;   // next pc on the predicted path

    // blocks a direct mapped cache holds after the refills seen so far
    fetch_pkg::block_addr_t held_blk [NUM_SETS];
    logic                   held_vld [NUM_SETS];
    fetch_pkg::block_addr_t refill_blk;   // requested, beat not back yet

    // note the mismatch and move on
    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Fail %0t: pc %h %s got %h expected %h", $time, exp_pc, field, got, want);
        errors = errors + 1;
    endtask

    initial begin
        dispatched = 0;
        errors     = 0;
    end

    always @(posedge clk or negedge arst_n) begin
        fetch_pkg::instr_t w;
        fetch_pkg::addr_t  imm;
        fetch_pkg::addr_t  nxt;
        logic              is_br;
        logic              is_jal;
        logic              taken;
        if (!arst_n) begin
            exp_pc = '0;   // boot address
        end else if (recovery_valid) begin
            exp_pc = recovery_pc;   // model restarts with the redirect
        end else if (dispatch_valid && dispatch_ready) begin
            w      = tb_program_word(exp_pc);
            is_br  = (w[6:0] == fetch_pkg::OPCODE_BRANCH);
            is_jal = (w[6:0] == fetch_pkg::OPCODE_JAL);
            if (is_jal)
                imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};   // j offset
            else
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};     // b offset
            taken = is_jal || (is_br && imm[31]);   // backward only
            nxt   = taken ? exp_pc + imm : exp_pc + 32'd4;
            if (dispatch_pc !== exp_pc) report_mismatch("pc", dispatch_pc, exp_pc);
            if (dispatch_instr !== w) report_mismatch("instr", dispatch_instr, w);
            if (dispatch_is_cond_br !== is_br)
                report_mismatch("is_cond_br", dispatch_is_cond_br, is_br);
            if (dispatch_br_taken !== taken)
                report_mismatch("br_taken", dispatch_br_taken, taken);
            if (dispatch_br_target !== nxt)
                report_mismatch("br_target", dispatch_br_target, nxt);
            dispatched = dispatched + 1;
            exp_pc     = nxt;
        end
    end

    // a block is fetched once per stay in its set
    always @(posedge clk or negedge arst_n) begin
        logic [IDX_W-1:0] idx;
        if (!arst_n) begin
            foreach (held_vld[i])
                held_vld[i] = 1'b0;   // cold cache
        end else if (mem_req_valid && mem_req_ready) begin
            idx = mem_req_addr[IDX_W-1:0];
            if (held_vld[idx] && held_blk[idx] == mem_req_addr) begin
                $display("Fail %0t: block %h requested again while resident",
                         $time, mem_req_addr);
                errors = errors + 1;
            end
            refill_blk = mem_req_addr;
        end else if (mem_resp_valid) begin
            idx           = refill_blk[IDX_W-1:0];
            held_vld[idx] = 1'b1;         // evicts whatever tag was there
            held_blk[idx] = refill_blk;
        end
    end

endmodule

//--- verification/ifu_properties.sv
`timescale 1ns/1ps

// handshake rules on the memory and dispatch ports
module ifu_properties (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   mem_req_valid,
    input logic                   mem_req_ready,
    input fetch_pkg::block_addr_t mem_req_addr,
    input logic                   mem_resp_valid,
    input logic                   recovery_valid,
    input logic                   dispatch_valid,
    input logic                   dispatch_ready,
    input fetch_pkg::instr_t      dispatch_instr,
    input fetch_pkg::addr_t       dispatch_pc
);

    logic in_flight;   // request accepted, beat not back yet

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            in_flight <= 1'b1;
        end else if (mem_resp_valid) begin
            in_flight <= 1'b0;   // beat ends the wait
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("memory request dropped or changed before acceptance");

    no_req_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
        in_flight |-> !mem_req_valid)
        else $error("memory request while waiting for a beat");

    // a flush may cut the entry off, otherwise it must stay put
    dispatch_held: assert property (@(posedge clk) disable iff (!arst_n)
        dispatch_valid && !dispatch_ready && !recovery_valid |=>
        recovery_valid || (dispatch_valid && $stable(dispatch_pc) && $stable(dispatch_instr)))
        else $error("dispatch entry changed under back-pressure");

    quiet_after_recovery: assert property (@(posedge clk) disable iff (!arst_n)
        recovery_valid |=> !dispatch_valid)
        else $error("dispatch valid in the cycle after recovery");

endmodule

bind ifu ifu_properties props_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .recovery_valid (recovery_valid),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch_instr (dispatch_instr),
    .dispatch_pc    (dispatch_pc)
);

//--- verification/tb_ifu.sv
`timescale 1ns/1ps

module tb_ifu;

    localparam int NUM_TESTS  = 5;
    localparam int MISS_WORST = 40;     // cycles per dispatch, slow memory plus stalls
    localparam int MARGIN     = 2000;

    // start pc, count, dispatch ready %, memory ready %, stall %
    int t_pc    [NUM_TESTS] = '{32'h0, 32'h40, 32'h1000, 32'h0, 32'h2c};
    int t_cnt   [NUM_TESTS] = '{40, 60, 40, 40, 50};
    int t_drdy  [NUM_TESTS] = '{100, 50, 30, 70, 60};
    int t_mrdy  [NUM_TESTS] = '{100, 60, 50, 80, 40};
    int t_stall [NUM_TESTS] = '{0, 20, 30, 10, 25};

    logic clk, arst_n, recovery_valid, backend_stall;
    logic mem_req_valid, mem_req_ready, mem_resp_valid;
    logic dispatch_valid, dispatch_ready, dispatch_is_cond_br, dispatch_br_taken;
    fetch_pkg::addr_t       recovery_pc, dispatch_pc, dispatch_br_target;
    fetch_pkg::block_addr_t mem_req_addr;
    fetch_pkg::block_t      mem_resp_data;
    fetch_pkg::instr_t      dispatch_instr;
    int dispatched, errors, mem_pct, wait_cnt, requests, cycles, limit, target;
    fetch_pkg::block_addr_t pend_blk;

    ifu dut_i (.*);

    ifu_checker chk_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns
    end

    // memory model, one request in flight, 1 to 6 cycle latency
    initial begin
        logic accepted;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        wait_cnt       = 0;
        requests       = 0;
        forever begin
            @(posedge clk);
            accepted = mem_req_valid && mem_req_ready;   // pre-edge values
            if (accepted) pend_blk = mem_req_addr;
            #1;
            mem_resp_valid = 1'b0;
            if (wait_cnt > 0) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    mem_resp_valid = 1'b1;
                    mem_resp_data  = {chk_i.tb_program_word({pend_blk, 3'b100}),
                                      chk_i.tb_program_word({pend_blk, 3'b000})};
                end
            end
            if (accepted) begin
                wait_cnt = $urandom_range(1, 6);
                requests = requests + 1;
            end
            mem_req_ready = ($urandom % 100) < mem_pct;
        end
    end

    // hang guard
    initial begin
        cycles = 0;
        limit  = MARGIN;
        foreach (t_cnt[i]) limit = limit + t_cnt[i] * MISS_WORST;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles >= limit) begin
                $display("timeout: the run hung, dispatch count was not reached");
                $display("Checks failed");
                $finish;
            end
        end
    end

    initial begin
        int base_err;
        int base_req;
        void'($urandom(32'he6ed));   // one seed for the run
        arst_n         = 1'b0;
        recovery_valid = 1'b0;
        recovery_pc    = '0;
        backend_stall  = 1'b0;
        dispatch_ready = 1'b0;
        mem_pct        = 100;
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            #1;
            recovery_valid = 1'b1;      // redirect and flush
            recovery_pc    = t_pc[t];
            dispatch_ready = 1'b0;
            backend_stall  = 1'b0;
            mem_pct        = t_mrdy[t];
            base_err       = errors;
            base_req       = requests;
            target         = dispatched + t_cnt[t];
            @(posedge clk);
            #1 recovery_valid = 1'b0;
            while (dispatched < target) begin
                dispatch_ready = ($urandom % 100) < t_drdy[t];
                backend_stall  = ($urandom % 100) < t_stall[t];
                @(posedge clk);
                #1;
            end
            dispatch_ready = 1'b0;
            $display("test %0d start %h: %0d dispatched, %0d memory requests, %0d errors",
                     t, t_pc[t], t_cnt[t], requests - base_req, errors - base_err);
        end
        $display("%0d tests, %0d dispatches, %0d memory requests, %0d errors",
                 NUM_TESTS, dispatched, requests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
